//--- Makefile
# Verilator build and run of the snake game testbench
VERILATOR ?= verilator
TOP ?= tbSnakeGame
FILELIST ?= tb.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

# pass only when the run prints the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJDIR)

//--- common/paintIf.sv
/* box paint request bus, controller to painter */
`timescale 1ns/1ps

interface paintIf import snakePkg::*; ();

    // one-cycle request pulse
    logic start;
    // box description, stable while the painter runs
    xCoord_t originX;
    yCoord_t originY;
    boxEdge_t edgeLen;
    colour_t colour;
    // one-cycle pulse after the last pixel
    logic done;

    modport requester (
        output start, originX, originY, edgeLen, colour,
        input done
    );

    modport painter (
        input start, originX, originY, edgeLen, colour,
        output done
    );

endinterface

//--- common/snakePkg.sv
/* screen and box geometry, coordinate and colour types,
   apple spot table, direction and controller state enums */
package snakePkg;

    // screen in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    // coordinate fields sized to the screen, arithmetic wraps at field width
    typedef logic [$clog2(ScreenWidth)-1:0] xCoord_t;
    typedef logic [$clog2(ScreenHeight)-1:0] yCoord_t;

    // one bit per channel, r g b
    typedef logic [2:0] colour_t;

    // box edges
    localparam int SegmentSize = 10;
    localparam int AppleSize = 4;
    typedef logic [$clog2(SegmentSize+1)-1:0] boxEdge_t;

    // snake shape, one segment per SegmentSize history entries
    localparam int MaxLength = 6;
    localparam int HistoryDepth = MaxLength * SegmentSize;
    localparam int StartX = 80;
    localparam int StartY = 60;

    localparam colour_t AppleColour = 3'b100;
    localparam colour_t EraseColour = 3'b000;

    // apple spots, entry 0 only used once after reset
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
    } appleSpot_t;

    localparam int AppleSpotCount = 8;
    localparam appleSpot_t AppleSpots [AppleSpotCount] = '{
        '{x: 8'd30, y: 7'd30},
        '{x: 8'd10, y: 7'd20},
        '{x: 8'd70, y: 7'd90},
        '{x: 8'd60, y: 7'd100},
        '{x: 8'd20, y: 7'd80},
        '{x: 8'd50, y: 7'd10},
        '{x: 8'd90, y: 7'd50},
        '{x: 8'd120, y: 7'd40}
    };

    typedef enum logic [1:0] {Right, Down, Up, Left} direction_t;

    typedef enum logic [3:0] {
        Idle, PaintReq, PaintWait, KeyWait, TickWait,
        EraseReq, EraseWait, Collide, Move, EatTest, Over
    } gameState_t;

endpackage

//--- logic/boxPainter.sv
/* square box sweep, one pixel per cycle, x inner loop */
`timescale 1ns/1ps

module boxPainter import snakePkg::*; (
    input logic Clock,
    input logic reset,
    paintIf.painter req,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour,
    output logic plot
);

    logic busy;
    logic donePulse;
    boxEdge_t col;
    boxEdge_t row;
    logic lastCol;
    logic lastRow;

    assign lastCol = (col == req.edgeLen - boxEdge_t'(1));
    assign lastRow = (row == req.edgeLen - boxEdge_t'(1));

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            donePulse <= 1'b0;
            col <= '0;
            row <= '0;
        end
        else
        begin
            donePulse <= 1'b0;
            if (req.start)
            begin
                // first pixel one cycle after start
                busy <= 1'b1;
                col <= '0;
                row <= '0;
            end
            else if (busy)
            begin
                if (lastCol)
                begin
                    col <= '0;
                    if (lastRow)
                    begin
                        // done lands in the cycle after the last pixel
                        busy <= 1'b0;
                        donePulse <= 1'b1;
                    end
                    else
                        row <= row + boxEdge_t'(1);
                end
                else
                    col <= col + boxEdge_t'(1);
            end
        end
    end

    assign req.done = donePulse;
    assign plot = busy;
    assign pixelX = req.originX + xCoord_t'(col);
    assign pixelY = req.originY + yCoord_t'(row);
    assign pixelColour = req.colour;

    // requester waits for done before the next box
    assert property (@(posedge Clock) disable iff (reset) req.start |-> !busy);

endmodule

//--- logic/gameControl.sv
/* game FSM: frame tick, box request sequencing,
   collision test, move and eat pulses */
`timescale 1ns/1ps

module gameControl import snakePkg::*; #(
    parameter int TickCycles = 200,
    parameter int SnakeLength = MaxLength
) (
    input logic Clock,
    input logic reset,
    input logic go,
    input logic anyKey,
    input colour_t snakeColour,
    input logic hit,
    input logic eats,
    input xCoord_t headX,
    input yCoord_t headY,
    input xCoord_t bodyX [SnakeLength],
    input yCoord_t bodyY [SnakeLength],
    input xCoord_t appleX,
    input yCoord_t appleY,
    paintIf.requester req,
    output logic shift,
    output logic eat,
    output logic gameOver
);

    localparam int TickBits = $clog2(TickCycles);
    localparam int SegBits = $clog2(SnakeLength);
    localparam logic [SegBits-1:0] LastSeg = SegBits'(SnakeLength - 1);

    gameState_t state;
    logic [TickBits-1:0] tickCount;
    logic tick;
    logic [SegBits-1:0] segIndex;
    logic paintApple;
    logic firstFrame;
    logic frameStart;
    logic erasing;
    colour_t frameColour;

    // free-running frame counter, tick on the last count
    always_ff @(posedge Clock)
    begin
        if (reset || tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + TickBits'(1);
    end

    assign tick = (tickCount == TickBits'(TickCycles - 1));

    // a new paint pass starts here, apple first
    assign frameStart = (state == Idle && go) || (state == KeyWait && anyKey) ||
                        (state == EatTest);

    // snake colour sampled once per paint pass
    always_ff @(posedge Clock)
    begin
        if (frameStart)
            frameColour <= snakeColour;
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= Idle;
            segIndex <= '0;
            paintApple <= 1'b0;
            firstFrame <= 1'b1;
            gameOver <= 1'b0;
        end
        else
        begin
            case (state)
                Idle:
                    if (go)
                    begin
                        paintApple <= 1'b1;
                        state <= PaintReq;
                    end
                PaintReq:
                    state <= PaintWait;
                PaintWait:
                    if (req.done)
                    begin
                        if (paintApple)
                        begin
                            paintApple <= 1'b0;
                            state <= PaintReq;
                        end
                        else if (segIndex == LastSeg)
                        begin
                            segIndex <= '0;
                            // hold the first picture until a key
                            state <= firstFrame ? KeyWait : TickWait;
                        end
                        else
                        begin
                            segIndex <= segIndex + SegBits'(1);
                            state <= PaintReq;
                        end
                    end
                KeyWait:
                    if (anyKey)
                    begin
                        firstFrame <= 1'b0;
                        paintApple <= 1'b1;
                        state <= PaintReq;
                    end
                TickWait:
                    if (tick)
                        state <= EraseReq;
                EraseReq:
                    state <= EraseWait;
                EraseWait:
                    if (req.done)
                    begin
                        if (segIndex == LastSeg)
                        begin
                            segIndex <= '0;
                            state <= Collide;
                        end
                        else
                        begin
                            segIndex <= segIndex + SegBits'(1);
                            state <= EraseReq;
                        end
                    end
                Collide:
                    if (hit)
                    begin
                        gameOver <= 1'b1;
                        state <= Over;
                    end
                    else
                        state <= Move;
                // history shifts here, new head visible in EatTest
                Move:
                    state <= EatTest;
                EatTest:
                begin
                    paintApple <= 1'b1;
                    state <= PaintReq;
                end
                // frozen, no more requests
                Over:
                    state <= Over;
                default:
                    state <= Idle;
            endcase
        end
    end

    assign erasing = (state == EraseReq) || (state == EraseWait);

    // box request, held steady while the painter runs
    always_comb
    begin
        req.start = (state == PaintReq) || (state == EraseReq);
        if (paintApple)
        begin
            req.originX = appleX;
            req.originY = appleY;
            req.edgeLen = boxEdge_t'(AppleSize);
            req.colour = AppleColour;
        end
        else
        begin
            req.originX = (segIndex == '0) ? headX : bodyX[segIndex];
            req.originY = (segIndex == '0) ? headY : bodyY[segIndex];
            req.edgeLen = boxEdge_t'(SegmentSize);
            req.colour = erasing ? EraseColour : frameColour;
        end
    end

    assign shift = (state == Move);
    // eats already reflects the shifted head
    assign eat = (state == EatTest) && eats;

endmodule

//--- logic/snakeGame.sv
/* snake game core top level: controller, painter,
   steering, position history, collision and apple blocks */
`timescale 1ns/1ps

module snakeGame import snakePkg::*; #(
    parameter int TickCycles = 200,
    parameter int SnakeLength = MaxLength
) (
    input logic Clock,
    input logic reset,
    input logic go,
    input logic [3:0] keys,
    input colour_t snakeColour,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour,
    output logic plot,
    output logic [7:0] score,
    output logic gameOver
);

    paintIf paintBus ();

    xCoord_t xTaps [SnakeLength];
    yCoord_t yTaps [SnakeLength];
    xCoord_t nextX;
    yCoord_t nextY;
    xCoord_t appleX;
    yCoord_t appleY;
    logic anyKey;
    logic hit;
    logic eats;
    logic shift;
    logic eat;

    // head is tap 0 of each history
    segmentHistory #(
        .coord_t(xCoord_t),
        .Depth(SnakeLength * SegmentSize),
        .Taps(SnakeLength),
        .HeadStart(xCoord_t'(StartX)),
        .BlockStep(xCoord_t'(0))
    ) historyX (
        .Clock(Clock), .reset(reset), .shift(shift), .newHead(nextX), .taps(xTaps)
    );

    // body laid out straight down from the head
    segmentHistory #(
        .coord_t(yCoord_t),
        .Depth(SnakeLength * SegmentSize),
        .Taps(SnakeLength),
        .HeadStart(yCoord_t'(StartY)),
        .BlockStep(yCoord_t'(SegmentSize))
    ) historyY (
        .Clock(Clock), .reset(reset), .shift(shift), .newHead(nextY), .taps(yTaps)
    );

    snakeSteer steer (
        .Clock(Clock), .reset(reset), .keys(keys), .headX(xTaps[0]), .headY(yTaps[0]),
        .nextX(nextX), .nextY(nextY), .anyKey(anyKey)
    );

    collisionCheck #(.SnakeLength(SnakeLength)) collide (
        .headX(xTaps[0]), .headY(yTaps[0]), .bodyX(xTaps), .bodyY(yTaps),
        .appleX(appleX), .appleY(appleY), .hit(hit), .eats(eats)
    );

    appleSpawner apple (
        .Clock(Clock), .reset(reset), .eat(eat),
        .appleX(appleX), .appleY(appleY), .score(score)
    );

    gameControl #(.TickCycles(TickCycles), .SnakeLength(SnakeLength)) control (
        .Clock(Clock), .reset(reset), .go(go), .anyKey(anyKey), .snakeColour(snakeColour),
        .hit(hit), .eats(eats), .headX(xTaps[0]), .headY(yTaps[0]),
        .bodyX(xTaps), .bodyY(yTaps), .appleX(appleX), .appleY(appleY),
        .req(paintBus.requester), .shift(shift), .eat(eat), .gameOver(gameOver)
    );

    boxPainter painter (
        .Clock(Clock), .reset(reset), .req(paintBus.painter),
        .pixelX(pixelX), .pixelY(pixelY), .pixelColour(pixelColour), .plot(plot)
    );

endmodule

//--- snake/appleSpawner.sv
/* apple position from the spot table, score counter */
`timescale 1ns/1ps

module appleSpawner import snakePkg::*; (
    input logic Clock,
    input logic reset,
    input logic eat,
    output xCoord_t appleX,
    output yCoord_t appleY,
    output logic [7:0] score
);

    localparam int IndexBits = $clog2(AppleSpotCount);

    logic [IndexBits-1:0] spotIndex;
    logic [IndexBits-1:0] nextIndex;

    // entry 0 is the start spot only, the loop restarts at entry 1
    always_comb
    begin
        if (spotIndex == IndexBits'(AppleSpotCount - 1))
            nextIndex = IndexBits'(1);
        else
            nextIndex = spotIndex + IndexBits'(1);
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            spotIndex <= '0;
            score <= '0;
        end
        else if (eat)
        begin
            spotIndex <= nextIndex;
            // saturate at 255
            if (score != 8'hFF)
                score <= score + 8'd1;
        end
    end

    assign appleX = AppleSpots[spotIndex].x;
    assign appleY = AppleSpots[spotIndex].y;

    // start spot never comes back once left
    assert property (@(posedge Clock) disable iff (reset) spotIndex != '0 |=> spotIndex != '0);

endmodule

//--- snake/collisionCheck.sv
/* head box against body boxes and against the apple box */
`timescale 1ns/1ps

module collisionCheck import snakePkg::*; #(
    parameter int SnakeLength = MaxLength
) (
    input xCoord_t headX,
    input yCoord_t headY,
    input xCoord_t bodyX [SnakeLength],
    input yCoord_t bodyY [SnakeLength],
    input xCoord_t appleX,
    input yCoord_t appleY,
    output logic hit,
    output logic eats
);

    // open-interval overlap on both axes
    // sums done in int width, so box edges do not wrap
    function automatic logic boxesOverlap(input int ax, input int ay, input int aSize,
                                          input int bx, input int by, input int bSize);
        logic overlapX;
        logic overlapY;
        overlapX = (ax < bx + bSize) && (ax + aSize > bx);
        overlapY = (ay < by + bSize) && (ay + aSize > by);
        return overlapX && overlapY;
    endfunction

    always_comb
    begin
        hit = 1'b0;
        // segments 0 and 1 always touch the head
        for (int k = 2; k < SnakeLength; k++)
        begin
            if (boxesOverlap(int'(headX), int'(headY), SegmentSize,
                             int'(bodyX[k]), int'(bodyY[k]), SegmentSize))
                hit = 1'b1;
        end
    end

    assign eats = boxesOverlap(int'(headX), int'(headY), SegmentSize,
                               int'(appleX), int'(appleY), AppleSize);

endmodule

//--- snake/segmentHistory.sv
/* position history for one coordinate, entry 0 is the head,
   one tap per segment */
`timescale 1ns/1ps

module segmentHistory import snakePkg::*; #(
    parameter type coord_t = xCoord_t,
    parameter int Depth = HistoryDepth,
    parameter int Taps = MaxLength,
    parameter coord_t HeadStart = '0,
    parameter coord_t BlockStep = '0
) (
    input logic Clock,
    input logic reset,
    input logic shift,
    input coord_t newHead,
    output coord_t taps [Taps]
);

    // entries per segment
    localparam int Spacing = Depth / Taps;

    coord_t history [Depth];

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // preset: block k sits at HeadStart + k * BlockStep
            for (int i = 0; i < Depth; i++)
                history[i] <= HeadStart + coord_t'((i / Spacing) * BlockStep);
        end
        else if (shift)
        begin
            // new head enters, everything moves one entry toward the tail
            history[0] <= newHead;
            for (int i = 1; i < Depth; i++)
                history[i] <= history[i-1];
        end
    end

    // segment k reads entry k * Spacing
    for (genvar k = 0; k < Taps; k++)
    begin : gTap
        assign taps[k] = history[k*Spacing];
    end

    // controller must hold off moves until reset is released
    assert property (@(posedge Clock) reset |-> !shift);

endmodule

//--- snake/snakeSteer.sv
/* direction latch from the keys and next head position */
`timescale 1ns/1ps

module snakeSteer import snakePkg::*; (
    input logic Clock,
    input logic reset,
    input logic [3:0] keys,
    input xCoord_t headX,
    input yCoord_t headY,
    output xCoord_t nextX,
    output yCoord_t nextY,
    output logic anyKey
);

    direction_t heading;

    // keys: 0 right, 1 down, 2 up, 3 left
    // lowest index wins, no key keeps the old heading
    always_ff @(posedge Clock)
    begin
        if (reset)
            heading <= Up;
        else if (keys[0])
            heading <= Right;
        else if (keys[1])
            heading <= Down;
        else if (keys[2])
            heading <= Up;
        else if (keys[3])
            heading <= Left;
    end

    assign anyKey = |keys;

    // one pixel step, wraps at the field width
    always_comb
    begin
        nextX = headX;
        nextY = headY;
        case (heading)
            Right: nextX = headX + xCoord_t'(1);
            Left:  nextX = headX - xCoord_t'(1);
            Down:  nextY = headY + yCoord_t'(1);
            Up:    nextY = headY - yCoord_t'(1);
        endcase
    end

endmodule

//--- tb.f
+incdir+verification
common/snakePkg.sv
common/paintIf.sv
snake/segmentHistory.sv
snake/snakeSteer.sv
snake/collisionCheck.sv
snake/appleSpawner.sv
logic/boxPainter.sv
logic/gameControl.sv
logic/snakeGame.sv
verification/tbSnakeGame.sv

//--- verification/snakeModel.svh
/* testbench model: position history, apple walk, score,
   game over and the predicted pixel stream */
`ifndef SNAKE_MODEL_SVH
`define SNAKE_MODEL_SVH

// coordinate field sizes, positions wrap here
localparam int XWrap = 256;
localparam int YWrap = 128;

// apple walk: spot 0 once, then spots 1 to 7 in a loop
localparam int SpotX [8] = '{30, 10, 70, 60, 20, 50, 90, 120};
localparam int SpotY [8] = '{30, 20, 90, 100, 80, 10, 50, 40};

// entry 0 is the head, segment k at entry k * SegmentSize
int modelX [HistoryDepth];
int modelY [HistoryDepth];
int modelSpot;
int modelScore;
bit modelOver;

// predicted pixels as {x, y, colour}, 18 bits, oldest first
logic [17:0] pixelQueue [$];

// one axis of the box test, open intervals
function automatic bit spansOverlap(input int a, input int aSize, input int b, input int bSize);
    return (a < b + bSize) && (b < a + aSize);
endfunction

function automatic void resetModel();
    // straight column below the head
    for (int i = 0; i < HistoryDepth; i++)
    begin
        modelX[i] = StartX;
        modelY[i] = StartY + SegmentSize * (i / SegmentSize);
    end
    modelSpot = 0;
    modelScore = 0;
    modelOver = 1'b0;
    pixelQueue.delete();
endfunction

// collision on the old head, then move, then eat on the new head
function automatic void stepModel(input direction_t dir);
    int headX;
    int headY;
    headX = modelX[0];
    headY = modelY[0];
    for (int k = 2; k < MaxLength; k++)
    begin
        if (spansOverlap(headX, SegmentSize, modelX[k*SegmentSize], SegmentSize) &&
            spansOverlap(headY, SegmentSize, modelY[k*SegmentSize], SegmentSize))
            modelOver = 1'b1;
    end
    if (modelOver)
        return;
    case (dir)
        Right: headX = (headX + 1) % XWrap;
        Left:  headX = (headX + XWrap - 1) % XWrap;
        Down:  headY = (headY + 1) % YWrap;
        Up:    headY = (headY + YWrap - 1) % YWrap;
    endcase
    for (int i = HistoryDepth - 1; i > 0; i--)
    begin
        modelX[i] = modelX[i-1];
        modelY[i] = modelY[i-1];
    end
    modelX[0] = headX;
    modelY[0] = headY;
    if (spansOverlap(headX, SegmentSize, SpotX[modelSpot], AppleSize) &&
        spansOverlap(headY, SegmentSize, SpotY[modelSpot], AppleSize))
    begin
        modelSpot = (modelSpot == 7) ? 1 : modelSpot + 1;
        if (modelScore < 255)
            modelScore++;
    end
endfunction

// row by row, x inner, origin wraps at field width
function automatic void pushBox(input int x, input int y, input int size, input colour_t colour);
    for (int r = 0; r < size; r++)
        for (int c = 0; c < size; c++)
            pixelQueue.push_back({xCoord_t'(x + c), yCoord_t'(y + r), colour});
endfunction

function automatic void pushPicture(input colour_t colour);
    pushBox(SpotX[modelSpot], SpotY[modelSpot], AppleSize, 3'b100);
    for (int k = 0; k < MaxLength; k++)
        pushBox(modelX[k*SegmentSize], modelY[k*SegmentSize], SegmentSize, colour);
endfunction

function automatic void pushErase();
    for (int k = 0; k < MaxLength; k++)
        pushBox(modelX[k*SegmentSize], modelY[k*SegmentSize], SegmentSize, 3'b000);
endfunction

`endif

//--- verification/tbSnakeGame.sv
/* snake game testbench: clock, reset, random play from a fixed seed,
   pixel stream checked against the model, per-test report */
`timescale 1ns/1ps

module tbSnakeGame import snakePkg::*; ();

    localparam int TickCycles = 200;
    localparam int FrameCycles = 1300 + TickCycles;
    localparam int EatLeftFrames = 47;
    localparam int EatUpFrames = 30;
    localparam int RandomFrames = 40;
    localparam int CrashFrames = 4;
    // start frames, quiet windows, margin
    localparam int SpareFrames = 14;
    localparam int CycleLimit =
        (EatLeftFrames + EatUpFrames + RandomFrames + CrashFrames + SpareFrames) * FrameCycles;
    localparam logic [31:0] Seed = 32'hbdf7_2337;

    logic Clock;
    logic reset;
    logic go;
    logic [3:0] keys;
    colour_t snakeColour;
    xCoord_t pixelX;
    yCoord_t pixelY;
    colour_t pixelColour;
    logic plot;
    logic [7:0] score;
    logic gameOver;

    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int failedTests = 0;
    int testErrorsAtStart = 0;
    int pixelCount = 0;

    `include "snakeModel.svh"

    snakeGame #(.TickCycles(TickCycles)) DUT (
        .Clock(Clock), .reset(reset), .go(go), .keys(keys), .snakeColour(snakeColour),
        .pixelX(pixelX), .pixelY(pixelY), .pixelColour(pixelColour), .plot(plot),
        .score(score), .gameOver(gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    task automatic compareValues(input string what, input logic [31:0] actual,
                                 input logic [31:0] expectedValue);
        checkCount++;
        if (actual !== expectedValue)
        begin
            errorCount++;
            $display("mismatch at %0t: %s, got %0h expected %0h",
                     $time, what, actual, expectedValue);
        end
    endtask

    // watchdog
    always @(posedge Clock)
    begin
        cycleCount++;
        if (cycleCount > CycleLimit)
        begin
            $display("timeout after %0d cycles, the predicted pixels never all arrived",
                     cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // every plotted pixel must be the next predicted one
    always @(negedge Clock)
    begin
        if (plot !== 1'b0)
        begin
            if (pixelQueue.size() == 0)
            begin
                errorCount++;
                $display("unexpected plot at %0t when no pixel was predicted", $time);
            end
            else
                compareValues($sformatf("pixel %0d {x,y,colour}", pixelCount),
                              32'({pixelX, pixelY, pixelColour}), 32'(pixelQueue.pop_front()));
            pixelCount++;
        end
    end

    function automatic logic [3:0] keyFor(input direction_t dir);
        case (dir)
            Right:   return 4'b0001;
            Down:    return 4'b0010;
            Up:      return 4'b0100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic direction_t reverseOf(input direction_t dir);
        case (dir)
            Right:   return Left;
            Left:    return Right;
            Up:      return Down;
            default: return Up;
        endcase
    endfunction

    task automatic nextDriveSlot();
        @(posedge Clock);
        #1;
    endtask

    task automatic waitDrained();
        while (pixelQueue.size() != 0)
            @(negedge Clock);
    endtask

    // plot must stay low, the monitor flags anything else
    task automatic watchQuiet(input int cycles);
        repeat (cycles) @(negedge Clock);
    endtask

    task automatic startGame();
        nextDriveSlot();
        reset = 1'b1;
        go = 1'b0;
        keys = 4'b0000;
        resetModel();
        repeat (5) @(posedge Clock);
        #1;
        reset = 1'b0;
    endtask

    task automatic paintFirstFrame(input colour_t colour);
        nextDriveSlot();
        snakeColour = colour;
        pushPicture(colour);
        go = 1'b1;
        waitDrained();
    endtask

    // first key repaints the start picture
    task automatic pressFirstKey(input direction_t dir, input colour_t colour);
        nextDriveSlot();
        snakeColour = colour;
        keys = keyFor(dir);
        pushPicture(colour);
        waitDrained();
    endtask

    task automatic beginPlay(input direction_t dir);
        startGame();
        paintFirstFrame(colour_t'($urandom_range(7)));
        pressFirstKey(dir, colour_t'($urandom_range(7)));
    endtask

    // erase, step, repaint; colour lands in the repaint of this frame
    task automatic runFrame(input direction_t dir, input colour_t colour);
        nextDriveSlot();
        keys = keyFor(dir);
        snakeColour = colour;
        pushErase();
        stepModel(dir);
        if (!modelOver)
            pushPicture(colour);
        waitDrained();
        // collide to gameOver takes a few fixed cycles
        if (modelOver)
            repeat (4) @(negedge Clock);
        compareValues("score", 32'(score), 32'(modelScore));
        compareValues("gameOver", 32'(gameOver), 32'(modelOver));
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == testErrorsAtStart)
            $display("test %0d %s: ok", testCount, name);
        else
        begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errorCount - testErrorsAtStart);
        end
        testErrorsAtStart = errorCount;
    endtask

    initial
    begin
        int frames;
        int holdFrames;
        direction_t heldDir;
        direction_t nextDir;
        reset = 1'b1;
        go = 1'b0;
        keys = 4'b0000;
        snakeColour = 3'b000;
        void'($urandom(Seed));

        // idle after reset until go
        startGame();
        @(negedge Clock);
        compareValues("plot after reset", 32'(plot), 0);
        compareValues("score after reset", 32'(score), 0);
        compareValues("gameOver after reset", 32'(gameOver), 0);
        watchQuiet(50);
        compareValues("score before go", 32'(score), 0);
        compareValues("gameOver before go", 32'(gameOver), 0);
        finishTest("reset state");

        // start picture, then nothing until a key
        paintFirstFrame(colour_t'($urandom_range(7)));
        watchQuiet(3 * TickCycles);
        finishTest("first frame");

        // left then up runs the head into the first apple spot
        beginPlay(Left);
        for (int f = 0; f < EatLeftFrames; f++)
            runFrame(Left, colour_t'($urandom_range(7)));
        for (int f = 0; f < EatUpFrames; f++)
            runFrame(Up, colour_t'($urandom_range(7)));
        compareValues("score after apple", 32'(score), 1);
        finishTest("apple eaten");

        // random headings, never straight back into the body
        heldDir = Up;
        nextDir = direction_t'($urandom_range(3));
        if (nextDir == reverseOf(heldDir))
            nextDir = heldDir;
        beginPlay(nextDir);
        heldDir = nextDir;
        frames = 0;
        while (frames < RandomFrames && !modelOver)
        begin
            holdFrames = $urandom_range(6, 1);
            for (int f = 0; f < holdFrames && frames < RandomFrames && !modelOver; f++)
            begin
                runFrame(nextDir, colour_t'($urandom_range(7)));
                frames++;
            end
            heldDir = nextDir;
            nextDir = direction_t'($urandom_range(3));
            if (nextDir == reverseOf(heldDir))
                nextDir = heldDir;
        end
        if (modelOver)
            watchQuiet(2 * FrameCycles);
        finishTest("random play");

        // reversing drives the head into segment 2
        beginPlay(Down);
        for (int f = 0; f < CrashFrames && !modelOver; f++)
            runFrame(Down, colour_t'($urandom_range(7)));
        compareValues("gameOver after crash", 32'(gameOver), 1);
        watchQuiet(2 * FrameCycles);
        finishTest("self collision");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
